// ==== common/lat_dpram_consts.svh ====
// Latency DPRAM constants

`ifndef LAT_DPRAM_CONSTS_SVH
`define LAT_DPRAM_CONSTS_SVH

// width of one memory word in bits
`define LAT_DATA_WIDTH 8

// number of words held by the RAM
`define LAT_MEM_DEPTH 16

// address width, enough to reach every word of the RAM
`define LAT_ADDR_WIDTH 4

// port A latencies as plain counts of added cycles
// write latency is the number of cycles a command waits before the RAM sees it
`define LAT_WR_LATENCY_A 2

// read latency is the number of cycles added after the RAM read register
`define LAT_RD_LATENCY_A 1

// port B latencies, counted the same way as for port A
`define LAT_WR_LATENCY_B 3

// a read latency of zero means the RAM read register drives the port directly
`define LAT_RD_LATENCY_B 0

// total read turnaround on each port is write latency plus one plus read latency
// with the values above both ports return read data four cycles after the request

`endif

// ==== common/lat_dpram_pkg.sv ====
// Latency DPRAM shared types

`default_nettype none

`include "lat_dpram_consts.svh"

package lat_dpram_pkg;

  // one memory word
  typedef logic [`LAT_DATA_WIDTH-1:0] data_t;

  // one word address
  typedef logic [`LAT_ADDR_WIDTH-1:0] addr_t;

  // one port command as it travels down the write delay line
  // en low marks an idle cycle and the other fields are then don't care
  // en high with we high is a write of wdata to addr
  // en high with we low is a read of addr
  typedef struct packed {
    logic  en;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_cmd_t;

  // one read response as it travels down the read delay line
  // valid is high for exactly one cycle per read command
  // data is only meaningful while valid is high
  typedef struct packed {
    logic  valid;
    data_t data;
  } rd_resp_t;

  // a cleared command is an idle cycle
  // the delay lines rely on this when they reset to all zeros
  // a cleared response is likewise an empty slot with valid low
  // so the all zero reset value of both types is always harmless

endpackage

`default_nettype wire

// ==== src/lat_delay_line.sv ====
// Configurable depth delay line

`timescale 1ns/100ps
`default_nettype none

module lat_delay_line #(
  // payload carried through the line, any packed type
  parameter type    payload_t = logic,
  // number of register stages, zero gives a straight connection
  parameter integer DEPTH     = 1
) (
  input  wire           clka,
  input  wire           i_rst_n,
  input  wire payload_t i_data,
  output payload_t      o_data
);

  // a negative depth has no meaning for a shift register
  if (DEPTH < 0)
  begin : g_bad_depth
    $error("lat_delay_line needs DEPTH of zero or more");
  end

  if (DEPTH == 0)
  begin : g_bypass
    // no stages so the payload passes through within the same cycle
    assign o_data = i_data;
  end
  else
  begin : g_pipe
    localparam integer CNT_W = $clog2(DEPTH + 1);

    // stage 0 takes the input and the last stage feeds the output
    payload_t stage_q [DEPTH];

    // counts cycles since reset was released, saturating at DEPTH
    logic [CNT_W-1:0] run_cnt_q;

    always_ff @(posedge clka)
    begin
      if (!i_rst_n)
      begin
        // every stage clears so enables and valids start inactive
        for (int i = 0; i < DEPTH; i++)
        begin
          stage_q[i] <= payload_t'('0);
        end
      end
      else
      begin
        stage_q[0] <= i_data;
        // shift one place per cycle toward the output
        for (int i = 1; i < DEPTH; i++)
        begin
          stage_q[i] <= stage_q[i-1];
        end
      end
    end

    assign o_data = stage_q[DEPTH-1];

    // the line is only fully loaded with live data DEPTH cycles after reset
    always_ff @(posedge clka)
    begin
      if (!i_rst_n)
      begin
        run_cnt_q <= '0;
      end
      else if (run_cnt_q != CNT_W'(DEPTH))
      begin
        run_cnt_q <= run_cnt_q + 1'b1;
      end
    end

    // once the line is full the output is the input from DEPTH edges before
    a_delay_exact : assert property (
      @(posedge clka) disable iff (!i_rst_n)
      (run_cnt_q == CNT_W'(DEPTH)) |-> (o_data == $past(i_data, DEPTH))
    );
  end

endmodule

`default_nettype wire

// ==== dpram/dpram_core.sv ====
// Two port synchronous RAM core

`timescale 1ns/100ps
`default_nettype none

`include "lat_dpram_consts.svh"

module dpram_core (
  input  wire                          clka,
  input  wire                          i_rst_n,
  input  wire lat_dpram_pkg::mem_cmd_t i_cmd_a,
  input  wire lat_dpram_pkg::mem_cmd_t i_cmd_b,
  output lat_dpram_pkg::rd_resp_t      o_resp_a,
  output lat_dpram_pkg::rd_resp_t      o_resp_b
);

  import lat_dpram_pkg::*;

  // storage array whose contents survive reset
  data_t mem [`LAT_MEM_DEPTH];

  // decoded command kinds per port
  logic wr_a;
  logic wr_b;
  logic rd_a;
  logic rd_b;

  // registered read data per port
  data_t rd_data_a_q;
  data_t rd_data_b_q;

  // registered read valid flags per port
  logic rd_valid_a_q;
  logic rd_valid_b_q;

  assign wr_a = i_cmd_a.en && i_cmd_a.we;
  assign wr_b = i_cmd_b.en && i_cmd_b.we;
  assign rd_a = i_cmd_a.en && !i_cmd_a.we;
  assign rd_b = i_cmd_b.en && !i_cmd_b.we;

  // both ports write in one block
  // port B is applied last so it wins when both hit the same word
  always_ff @(posedge clka)
  begin
    if (wr_a)
    begin
      mem[i_cmd_a.addr] <= i_cmd_a.wdata;
    end
    if (wr_b)
    begin
      mem[i_cmd_b.addr] <= i_cmd_b.wdata;
    end
  end

  // read first behaviour
  // the array is sampled before this edge's writes land
  // so a read of a word being written by either port returns the old word
  always_ff @(posedge clka)
  begin
    if (rd_a)
    begin
      rd_data_a_q <= mem[i_cmd_a.addr];
    end
    if (rd_b)
    begin
      rd_data_b_q <= mem[i_cmd_b.addr];
    end
  end

  // valid follows the read enable by exactly one cycle
  always_ff @(posedge clka)
  begin
    if (!i_rst_n)
    begin
      rd_valid_a_q <= 1'b0;
      rd_valid_b_q <= 1'b0;
    end
    else
    begin
      rd_valid_a_q <= rd_a;
      rd_valid_b_q <= rd_b;
    end
  end

  // responses go out as a struct for the read delay lines
  assign o_resp_a.valid = rd_valid_a_q;
  assign o_resp_a.data  = rd_data_a_q;
  assign o_resp_b.valid = rd_valid_b_q;
  assign o_resp_b.data  = rd_data_b_q;

  // a read command on the port always produces a response on the next cycle
  property p_read_gives_resp(logic en, logic we, logic valid);
    @(posedge clka) disable iff (!i_rst_n)
    (en && !we) |=> valid;
  endproperty

  // a response never appears unless the port carried a read one cycle earlier
  property p_no_spurious_resp(logic en, logic we, logic valid);
    @(posedge clka) disable iff (!i_rst_n)
    !(en && !we) |=> !valid;
  endproperty

  a_resp_a : assert property (p_read_gives_resp(i_cmd_a.en, i_cmd_a.we, o_resp_a.valid));
  a_resp_b : assert property (p_read_gives_resp(i_cmd_b.en, i_cmd_b.we, o_resp_b.valid));

  a_quiet_a : assert property (p_no_spurious_resp(i_cmd_a.en, i_cmd_a.we, o_resp_a.valid));
  a_quiet_b : assert property (p_no_spurious_resp(i_cmd_b.en, i_cmd_b.we, o_resp_b.valid));

endmodule

`default_nettype wire

// ==== src/latency_dpram_top.sv ====
// Dual port RAM with per port latency

`timescale 1ns/100ps
`default_nettype none

`include "lat_dpram_consts.svh"

module latency_dpram_top (
  input  wire                       clka,
  input  wire                       i_rst_n,

  // port A command inputs
  input  wire                       i_en_a,
  input  wire                       i_we_a,
  input  wire lat_dpram_pkg::addr_t i_addr_a,
  input  wire lat_dpram_pkg::data_t i_wdata_a,

  // port A read outputs
  output lat_dpram_pkg::data_t      o_rd_data_a,
  output logic                      o_rd_valid_a,

  // port B command inputs
  input  wire                       i_en_b,
  input  wire                       i_we_b,
  input  wire lat_dpram_pkg::addr_t i_addr_b,
  input  wire lat_dpram_pkg::data_t i_wdata_b,

  // port B read outputs
  output lat_dpram_pkg::data_t      o_rd_data_b,
  output logic                      o_rd_valid_b
);

  import lat_dpram_pkg::*;

  // commands as presented on the ports
  mem_cmd_t cmd_a_in;
  mem_cmd_t cmd_b_in;

  // commands after the write latency, as the RAM sees them
  mem_cmd_t cmd_a_ram;
  mem_cmd_t cmd_b_ram;

  // responses straight out of the RAM read register
  rd_resp_t resp_a_ram;
  rd_resp_t resp_b_ram;

  // responses after the read latency, as the ports see them
  rd_resp_t resp_a_out;
  rd_resp_t resp_b_out;

  // gather the loose port signals into one command word per port
  assign cmd_a_in = '{en: i_en_a, we: i_we_a, addr: i_addr_a, wdata: i_wdata_a};
  assign cmd_b_in = '{en: i_en_b, we: i_we_b, addr: i_addr_b, wdata: i_wdata_b};

  // port A write latency
  // enable, write enable, address and data all move together
  lat_delay_line #(
    .payload_t (mem_cmd_t),
    .DEPTH     (`LAT_WR_LATENCY_A)
  ) u_wr_delay_a (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_data  (cmd_a_in),
    .o_data  (cmd_a_ram)
  );

  // port B write latency
  lat_delay_line #(
    .payload_t (mem_cmd_t),
    .DEPTH     (`LAT_WR_LATENCY_B)
  ) u_wr_delay_b (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_data  (cmd_b_in),
    .o_data  (cmd_b_ram)
  );

  // the RAM adds one cycle of its own for the read register
  dpram_core u_ram (
    .clka     (clka),
    .i_rst_n  (i_rst_n),
    .i_cmd_a  (cmd_a_ram),
    .i_cmd_b  (cmd_b_ram),
    .o_resp_a (resp_a_ram),
    .o_resp_b (resp_b_ram)
  );

  // port A read latency
  // valid rides with the data so it stays aligned at any depth
  lat_delay_line #(
    .payload_t (rd_resp_t),
    .DEPTH     (`LAT_RD_LATENCY_A)
  ) u_rd_delay_a (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_data  (resp_a_ram),
    .o_data  (resp_a_out)
  );

  // port B read latency, depth zero turns this into a plain wire
  lat_delay_line #(
    .payload_t (rd_resp_t),
    .DEPTH     (`LAT_RD_LATENCY_B)
  ) u_rd_delay_b (
    .clka    (clka),
    .i_rst_n (i_rst_n),
    .i_data  (resp_b_ram),
    .o_data  (resp_b_out)
  );

  // split the responses back onto the loose output ports
  assign o_rd_data_a  = resp_a_out.data;
  assign o_rd_valid_a = resp_a_out.valid;
  assign o_rd_data_b  = resp_b_out.data;
  assign o_rd_valid_b = resp_b_out.valid;

endmodule

`default_nettype wire

// ==== verification/tb_latency_dpram.sv ====
// Latency DPRAM testbench

`timescale 1ns/100ps
`default_nettype none

`include "lat_dpram_consts.svh"

module tb_latency_dpram;

  import lat_dpram_pkg::*;

  localparam int WR_A = `LAT_WR_LATENCY_A;
  localparam int RD_A = `LAT_RD_LATENCY_A;
  localparam int WR_B = `LAT_WR_LATENCY_B;
  localparam int RD_B = `LAT_RD_LATENCY_B;
  localparam int WAIT_LIMIT = 40;

  // one expected response and the edge at which the DUT output must show it
  typedef struct {
    int    due;
    data_t data;
  } exp_resp_t;

  logic  clka;
  logic  i_rst_n;
  logic  i_en_a;
  logic  i_we_a;
  addr_t i_addr_a;
  data_t i_wdata_a;
  data_t o_rd_data_a;
  logic  o_rd_valid_a;
  logic  i_en_b;
  logic  i_we_b;
  addr_t i_addr_b;
  data_t i_wdata_b;
  data_t o_rd_data_b;
  logic  o_rd_valid_b;

  // model state that only the model block below writes
  data_t     model_mem [`LAT_MEM_DEPTH];
  mem_cmd_t  pipe_a_q [$];
  mem_cmd_t  pipe_b_q [$];
  exp_resp_t exp_a_q [$];
  exp_resp_t exp_b_q [$];
  int        cycle = 0;
  logic      exp_valid_a = 1'b0;
  logic      exp_valid_b = 1'b0;
  data_t     exp_data_a;
  data_t     exp_data_b;
  logic      rst_seen = 1'b0;

  latency_dpram_top i_dut (
    .clka         (clka),
    .i_rst_n      (i_rst_n),
    .i_en_a       (i_en_a),
    .i_we_a       (i_we_a),
    .i_addr_a     (i_addr_a),
    .i_wdata_a    (i_wdata_a),
    .o_rd_data_a  (o_rd_data_a),
    .o_rd_valid_a (o_rd_valid_a),
    .i_en_b       (i_en_b),
    .i_we_b       (i_we_b),
    .i_addr_b     (i_addr_b),
    .i_wdata_b    (i_wdata_b),
    .o_rd_data_b  (o_rd_data_b),
    .o_rd_valid_b (o_rd_valid_b)
  );

  initial
  begin
    clka = 1'b0;
    forever #20 clka = ~clka;
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Test failed");
    $fatal(1, "simulation stopped at the first failed check");
  endtask

  // the model sees each command at the edge that samples it
  // then holds it back by the write latency, the same way the DUT does
  always @(posedge clka)
  begin : model
    mem_cmd_t eff_a;
    mem_cmd_t eff_b;
    if (!i_rst_n)
    begin
      rst_seen <= 1'b1;
      pipe_a_q.delete();
      pipe_b_q.delete();
      exp_a_q.delete();
      exp_b_q.delete();
      exp_valid_a <= 1'b0;
      exp_valid_b <= 1'b0;
    end
    else
    begin
      pipe_a_q.push_back('{en: i_en_a, we: i_we_a, addr: i_addr_a, wdata: i_wdata_a});
      pipe_b_q.push_back('{en: i_en_b, we: i_we_b, addr: i_addr_b, wdata: i_wdata_b});
      // until the pipe is full the RAM only sees the cleared reset stages
      eff_a = '0;
      eff_b = '0;
      if (pipe_a_q.size() > WR_A)
      begin
        eff_a = pipe_a_q.pop_front();
      end
      if (pipe_b_q.size() > WR_B)
      begin
        eff_b = pipe_b_q.pop_front();
      end
      // reads take the old word before either write of this edge lands
      if (eff_a.en && !eff_a.we)
      begin
        exp_a_q.push_back('{due: cycle + 1 + RD_A, data: model_mem[eff_a.addr]});
      end
      if (eff_b.en && !eff_b.we)
      begin
        exp_b_q.push_back('{due: cycle + 1 + RD_B, data: model_mem[eff_b.addr]});
      end
      // port B goes last so it owns a shared address
      if (eff_a.en && eff_a.we)
      begin
        model_mem[eff_a.addr] = eff_a.wdata;
      end
      if (eff_b.en && eff_b.we)
      begin
        model_mem[eff_b.addr] = eff_b.wdata;
      end
      // expectation for the next edge, which the assertions sample there
      exp_valid_a <= 1'b0;
      exp_valid_b <= 1'b0;
      if (exp_a_q.size() != 0 && exp_a_q[0].due == cycle + 1)
      begin
        exp_valid_a <= 1'b1;
        exp_data_a  <= exp_a_q[0].data;
        void'(exp_a_q.pop_front());
      end
      if (exp_b_q.size() != 0 && exp_b_q[0].due == cycle + 1)
      begin
        exp_valid_b <= 1'b1;
        exp_data_b  <= exp_b_q[0].data;
        void'(exp_b_q.pop_front());
      end
    end
    cycle = cycle + 1;
  end

  // no valid may show while reset holds, once the first reset edge has cleared the stages
  a_reset_quiet : assert property (
    @(posedge clka) (!i_rst_n && rst_seen) |-> (!o_rd_valid_a && !o_rd_valid_b)
  )
  else
  begin
    abort_run("valid output went high while reset was asserted");
  end

  // valid must match the model on every cycle, which also rules out extra or stretched pulses
  a_valid_a : assert property (
    @(posedge clka) disable iff (!i_rst_n) o_rd_valid_a == exp_valid_a
  )
  else
  begin
    abort_run($sformatf("ERROR time=%0t o_rd_valid_a expected=%0b actual=%0b",
      $time, $sampled(exp_valid_a), $sampled(o_rd_valid_a)));
  end

  a_valid_b : assert property (
    @(posedge clka) disable iff (!i_rst_n) o_rd_valid_b == exp_valid_b
  )
  else
  begin
    abort_run($sformatf("ERROR time=%0t o_rd_valid_b expected=%0b actual=%0b",
      $time, $sampled(exp_valid_b), $sampled(o_rd_valid_b)));
  end

  a_data_a : assert property (
    @(posedge clka) disable iff (!i_rst_n) exp_valid_a |-> (o_rd_data_a == exp_data_a)
  )
  else
  begin
    abort_run($sformatf("ERROR time=%0t o_rd_data_a expected=%h actual=%h",
      $time, $sampled(exp_data_a), $sampled(o_rd_data_a)));
  end

  a_data_b : assert property (
    @(posedge clka) disable iff (!i_rst_n) exp_valid_b |-> (o_rd_data_b == exp_data_b)
  )
  else
  begin
    abort_run($sformatf("ERROR time=%0t o_rd_data_b expected=%h actual=%h",
      $time, $sampled(exp_data_b), $sampled(o_rd_data_b)));
  end

  task automatic next_cycle();
    @(posedge clka);
    #2;
  endtask

  task automatic set_port_a(input logic en, input logic we, input addr_t addr, input data_t wd);
    i_en_a    = en;
    i_we_a    = we;
    i_addr_a  = addr;
    i_wdata_a = wd;
  endtask

  task automatic set_port_b(input logic en, input logic we, input addr_t addr, input data_t wd);
    i_en_b    = en;
    i_we_b    = we;
    i_addr_b  = addr;
    i_wdata_b = wd;
  endtask

  // presents one read and counts cycles until its valid shows up
  // the value seen at each falling edge is the one the next rising edge samples
  task automatic timed_read(input bit on_b, input addr_t addr);
    int n;
    bit seen;
    int want;
    n = 0;
    seen = 1'b0;
    want = on_b ? (WR_B + 1 + RD_B) : (WR_A + 1 + RD_A);
    if (on_b)
    begin
      set_port_b(1'b1, 1'b0, addr, '0);
    end
    else
    begin
      set_port_a(1'b1, 1'b0, addr, '0);
    end
    next_cycle();
    set_port_a(1'b0, 1'b0, '0, '0);
    set_port_b(1'b0, 1'b0, '0, '0);
    while (!seen && n < WAIT_LIMIT)
    begin
      @(negedge clka);
      n++;
      seen = on_b ? o_rd_valid_b : o_rd_valid_a;
    end
    next_cycle();
    if (!seen)
    begin
      abort_run("timeout: no read valid arrived after a read command");
    end
    else if (n != want)
    begin
      abort_run($sformatf("ERROR time=%0t read_latency expected=%0d actual=%0d",
        $time, want, n));
    end
  endtask

  function automatic bit model_busy();
    bit busy;
    busy = (exp_a_q.size() != 0) || (exp_b_q.size() != 0);
    foreach (pipe_a_q[i])
    begin
      busy = busy || pipe_a_q[i].en;
    end
    foreach (pipe_b_q[i])
    begin
      busy = busy || pipe_b_q[i].en;
    end
    return busy;
  endfunction

  // lets every command in flight finish so the assertions see each response
  task automatic wait_drain();
    int n;
    n = 0;
    while (model_busy() && n < WAIT_LIMIT)
    begin
      @(negedge clka);
      n++;
    end
    if (model_busy())
    begin
      abort_run("timeout: responses were still outstanding after the drain window");
    end
    repeat (2) next_cycle();
  endtask

  initial
  begin
    void'($urandom(32'hb430));
    i_rst_n = 1'b0;
    set_port_a(1'b0, 1'b0, '0, '0);
    set_port_b(1'b0, 1'b0, '0, '0);
    repeat (5) next_cycle();
    i_rst_n = 1'b1;
    repeat (6) next_cycle();

    // fill every word so no read ever returns an unknown value
    for (int a = 0; a < `LAT_MEM_DEPTH; a++)
    begin
      set_port_a(1'b1, 1'b1, addr_t'(a), {addr_t'(a), ~addr_t'(a)});
      next_cycle();
    end
    set_port_a(1'b0, 1'b0, '0, '0);
    wait_drain();

    // write then read on port A with the latency counted by the timed read
    set_port_a(1'b1, 1'b1, 4'd3, 8'h5a);
    next_cycle();
    timed_read(1'b0, 4'd3);
    wait_drain();
    timed_read(1'b1, 4'd3);
    wait_drain();

    // port B write lands at t+3 and the port A read at t+4
    set_port_b(1'b1, 1'b1, 4'd7, 8'hc3);
    next_cycle();
    set_port_b(1'b0, 1'b0, '0, '0);
    next_cycle();
    timed_read(1'b0, 4'd7);
    wait_drain();

    // both writes reach address 9 at the same edge
    set_port_b(1'b1, 1'b1, 4'd9, 8'hb9);
    next_cycle();
    set_port_b(1'b0, 1'b0, '0, '0);
    set_port_a(1'b1, 1'b1, 4'd9, 8'ha9);
    next_cycle();
    set_port_a(1'b0, 1'b0, '0, '0);
    repeat (4) next_cycle();
    timed_read(1'b0, 4'd9);
    timed_read(1'b1, 4'd9);
    wait_drain();

    // back to back random traffic on both ports
    repeat (400)
    begin
      set_port_a($urandom_range(0, 3) != 0, $urandom_range(0, 1), addr_t'($urandom()),
        data_t'($urandom()));
      set_port_b($urandom_range(0, 3) != 0, $urandom_range(0, 1), addr_t'($urandom()),
        data_t'($urandom()));
      next_cycle();
    end
    set_port_a(1'b0, 1'b0, '0, '0);
    set_port_b(1'b0, 1'b0, '0, '0);
    wait_drain();

    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== latency_dpram_top.f ====
+incdir+common
common/lat_dpram_pkg.sv
src/lat_delay_line.sv
dpram/dpram_core.sv
src/latency_dpram_top.sv
verification/tb_latency_dpram.sv

// ==== Bender.yml ====
package:
  name: latency_dpram

export_include_dirs:
  - common

sources:
  # RTL in compile order
  - include_dirs:
      - common
    files:
      - common/lat_dpram_pkg.sv
      - src/lat_delay_line.sv
      - dpram/dpram_core.sv
      - src/latency_dpram_top.sv

  # testbench, top module tb_latency_dpram
  - target: test
    include_dirs:
      - common
    files:
      - verification/tb_latency_dpram.sv
